// File: Makefile
SOURCES := $(filter-out +%,$(shell cat files.f)) common/niu_params.svh

.PHONY: run clean

run: obj_dir/VniuCoreTb
	@out="$$(./obj_dir/VniuCoreTb +verilator+error+limit+1000)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "SIMULATION PASSED"

obj_dir/VniuCoreTb: files.f $(SOURCES)
	verilator --binary --timing --assert -Wno-fatal --top-module niuCoreTb \
		-f files.f -o VniuCoreTb

clean:
	rm -rf obj_dir

// File: common/niuPkg.sv
`include "niu_params.svh"

package niuPkg;

    // Primary opcode, instruction bits 31:27
    typedef enum logic [`NIU_OP_BITS-1:0] {
        ALUR = 5'b00000,
        ADDI = 5'b00001,
        MLTI = 5'b00010,
        ANDI = 5'b00101,
        ORI  = 5'b00110,
        XORI = 5'b00111,
        SULI = 5'b01000,
        SSLI = 5'b01001,
        SURI = 5'b01010,
        SSRI = 5'b01011,
        LW   = 5'b10000,
        SW   = 5'b10011,
        BEQ  = 5'b11000,
        BNE  = 5'b11001,
        BLT  = 5'b11010,
        BLE  = 5'b11011,
        JAL  = 5'b11111
    } primaryOp;

    // Immediate opcodes share their low values with these
    typedef enum logic [`NIU_OP_BITS-1:0] {
        SUB = 5'b00000,
        ADD = 5'b00001,
        MLT = 5'b00010,
        NOT = 5'b00100,
        AND = 5'b00101,
        OR  = 5'b00110,
        XOR = 5'b00111,
        SUL = 5'b01000,
        SSL = 5'b01001,
        SUR = 5'b01010,
        SSR = 5'b01011,
        EQ  = 5'b10000,
        NEQ = 5'b10001,
        LT  = 5'b10010,
        LEQ = 5'b10011
    } aluFunc;

    typedef enum logic [4:0] {
        FETCH, DECODE,
        ALUA, ALUB, ALUWB,
        MEMA, MEMB, MEMADDR, MEMACC,
        BRA, BRB, BRCMP, BRPCA, BRIMM, BRPCWB,
        JALLINK, JALPC,
        HALT
    } ctrlState;

    typedef enum logic [1:0] {SRC_REGDATA, SRC_IMMED, SRC_PCVAL} operandSrc;

    typedef enum logic [1:0] {WB_ALURES, WB_MEMDATA, WB_PCVAL} wbSrc;

    typedef struct packed {
        primaryOp                 op1;
        logic [`NIU_REG_BITS-1:0] rx;
        logic [`NIU_REG_BITS-1:0] ry;
        logic [`NIU_REG_BITS-1:0] rz;
        logic [`NIU_WORD-1:0]     imm;
        aluFunc                   op2;
    } decodedInstr;

    typedef struct packed {
        logic                     incPc;
        logic                     ldPc;
        logic                     ldIr;
        logic [`NIU_REG_BITS-1:0] regSel;
        logic                     wrReg;
        wbSrc                     wbSel;
        logic                     ldA;
        logic                     ldB;
        operandSrc                opSel;    // Also picks PC or ALU for adr and PC load
        logic                     immShift;
        aluFunc                   func;
        logic                     memStart;
        logic                     memWrite;
    } ctrlBundle;

    typedef struct packed {
        logic                 cyc;
        logic                 stb;
        logic                 we;
        logic [`NIU_WORD-1:0] adr;
        logic [`NIU_WORD-1:0] datW;
    } wbReq;

    typedef struct packed {
        logic [`NIU_WORD-1:0] datR;
        logic                 ack;
    } wbRsp;

endpackage

// File: common/niu_params.svh
`ifndef NIU_PARAMS_SVH
`define NIU_PARAMS_SVH

// Datapath word and field widths
`define NIU_WORD      32
`define NIU_REG_BITS  5
`define NIU_OP_BITS   5

// Program counter
`define NIU_PC_START  32'h0000_0000
`define NIU_PC_STEP   32'd4          // One instruction word

// Instruction field positions
`define NIU_OP1_MSB   31
`define NIU_OP1_LSB   27
`define NIU_RX_LSB    22
`define NIU_RY_LSB    17
`define NIU_RZ_LSB    12
`define NIU_IMM_BITS  17             // Sign-extended to NIU_WORD

`endif

// File: control/niuControl.sv
`timescale 1ns/1ns

module niuControl (
    input  logic                clk,
    input  logic                reset,
    input  niuPkg::decodedInstr instr,
    input  logic                memDone,
    input  logic                cond,
    output niuPkg::ctrlBundle   ctrl,
    output logic                halted
);
    import niuPkg::*;

    localparam ctrlBundle ctrlIdle = '0;

    ctrlState  state;
    ctrlState  stateNext;
    logic      phase;       // FETCH: read issued, DECODE: IR loaded
    logic      phaseNext;
    ctrlBundle ctrlNext;
    logic      isRegOp;
    aluFunc    cmpFunc;

    assign isRegOp = (instr.op1 == ALUR);
    assign halted  = (state == HALT);

    // Branch opcode to compare function
    always_comb begin
        case (instr.op1)
            BNE:     cmpFunc = NEQ;
            BLT:     cmpFunc = LT;
            BLE:     cmpFunc = LEQ;
            default: cmpFunc = EQ;
        endcase
    end

    // Each state picks the controls for the following cycle
    always_comb begin
        stateNext = state;
        phaseNext = phase;
        ctrlNext  = ctrlIdle;
        case (state)
            FETCH: begin
                if (!phase) begin
                    ctrlNext.memStart = 1'b1;
                    ctrlNext.opSel    = SRC_PCVAL;    // Address from PC
                    phaseNext         = 1'b1;
                end else if (memDone) begin
                    ctrlNext.ldIr  = 1'b1;
                    ctrlNext.incPc = 1'b1;
                    phaseNext      = 1'b0;
                    stateNext      = DECODE;
                end
            end
            DECODE: begin
                if (!phase) begin
                    phaseNext = 1'b1;     // IR is loading
                end else begin
                    phaseNext       = 1'b0;
                    ctrlNext.regSel = instr.rx;
                    ctrlNext.ldA    = 1'b1;
                    ctrlNext.opSel  = SRC_REGDATA;
                    case (instr.op1)
                        ALUR, ADDI, MLTI, ANDI, ORI, XORI, SULI, SSLI, SURI, SSRI:
                            stateNext = ALUA;
                        LW, SW:
                            stateNext = MEMA;
                        BEQ, BNE, BLT, BLE:
                            stateNext = BRA;
                        JAL: begin
                            ctrlNext        = ctrlIdle;
                            ctrlNext.regSel = instr.ry;   // Link first
                            ctrlNext.wrReg  = 1'b1;
                            ctrlNext.wbSel  = WB_PCVAL;
                            stateNext       = JALLINK;
                        end
                        default: begin
                            ctrlNext  = ctrlIdle;
                            stateNext = HALT;
                        end
                    endcase
                end
            end
            ALUA: begin
                ctrlNext.regSel = instr.ry;
                ctrlNext.ldB    = 1'b1;
                ctrlNext.opSel  = isRegOp ? SRC_REGDATA : SRC_IMMED;
                stateNext       = ALUB;
            end
            ALUB: begin
                // Immediate opcodes reuse the function encodings
                ctrlNext.func = isRegOp ? instr.op2 : aluFunc'(instr.op1);
                stateNext     = ALUWB;
            end
            ALUWB: begin
                ctrlNext.regSel = isRegOp ? instr.rz : instr.ry;
                ctrlNext.wrReg  = 1'b1;
                ctrlNext.wbSel  = WB_ALURES;
                stateNext       = FETCH;
            end
            MEMA: begin
                ctrlNext.ldB   = 1'b1;
                ctrlNext.opSel = SRC_IMMED;
                stateNext      = MEMB;
            end
            MEMB: begin
                ctrlNext.func = ADD;
                stateNext     = MEMADDR;
            end
            MEMADDR: begin
                ctrlNext.memStart = 1'b1;
                ctrlNext.memWrite = (instr.op1 == SW);
                ctrlNext.regSel   = instr.ry;         // Store data
                ctrlNext.opSel    = SRC_REGDATA;
                stateNext         = MEMACC;
            end
            MEMACC: begin
                if (memDone) begin
                    if (instr.op1 == LW) begin
                        ctrlNext.regSel = instr.ry;
                        ctrlNext.wrReg  = 1'b1;
                        ctrlNext.wbSel  = WB_MEMDATA;
                    end
                    stateNext = FETCH;
                end
            end
            BRA: begin
                ctrlNext.regSel = instr.ry;
                ctrlNext.ldB    = 1'b1;
                ctrlNext.opSel  = SRC_REGDATA;
                stateNext       = BRB;
            end
            BRB: begin
                ctrlNext.func = cmpFunc;
                stateNext     = BRCMP;
            end
            BRCMP: begin
                ctrlNext.ldA   = 1'b1;     // Harmless if not taken
                ctrlNext.opSel = SRC_PCVAL;
                stateNext      = BRPCA;
            end
            BRPCA: begin
                if (cond) begin
                    ctrlNext.ldB      = 1'b1;
                    ctrlNext.opSel    = SRC_IMMED;
                    ctrlNext.immShift = 1'b1;
                    stateNext         = BRIMM;
                end else begin
                    stateNext = FETCH;
                end
            end
            BRIMM: begin
                ctrlNext.func = ADD;
                stateNext     = BRPCWB;
            end
            BRPCWB: begin
                ctrlNext.ldPc  = 1'b1;
                ctrlNext.opSel = SRC_PCVAL;   // Target from ALU
                stateNext      = FETCH;
            end
            JALLINK: begin
                ctrlNext.regSel = instr.rx;
                ctrlNext.ldPc   = 1'b1;
                ctrlNext.opSel  = SRC_REGDATA;
                stateNext       = JALPC;
            end
            JALPC:   stateNext = FETCH;
            default: stateNext = HALT;   // Only reset leaves
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= FETCH;
            phase <= 1'b0;
            ctrl  <= ctrlIdle;
        end else begin
            state <= stateNext;
            phase <= phaseNext;
            ctrl  <= ctrlNext;
        end
    end

endmodule

// File: design/niuAlu.sv
`timescale 1ns/1ns
`include "niu_params.svh"

module niuAlu (
    input  logic                 clk,
    input  niuPkg::ctrlBundle    ctrl,
    input  logic [`NIU_WORD-1:0] regData,
    input  logic [`NIU_WORD-1:0] pc,
    input  logic [`NIU_WORD-1:0] imm,
    output logic [`NIU_WORD-1:0] result,
    output logic                 cond
);
    import niuPkg::*;

    logic [`NIU_WORD-1:0] opA;
    logic [`NIU_WORD-1:0] opB;
    logic [`NIU_WORD-1:0] operand;
    logic [`NIU_WORD-1:0] aluOut;
    logic [4:0]           shamt;

    // Operand select in front of A and B
    always_comb begin
        case (ctrl.opSel)
            SRC_IMMED: operand = ctrl.immShift ? (imm << 2) : imm;   // Branch offset in words
            SRC_PCVAL: operand = pc;
            default:   operand = regData;
        endcase
    end

    assign shamt = opB[4:0];

    always_comb begin
        case (ctrl.func)
            SUB:     aluOut = opA - opB;
            ADD:     aluOut = opA + opB;
            MLT:     aluOut = opA * opB;       // Low word only
            NOT:     aluOut = ~opA;
            AND:     aluOut = opA & opB;
            OR:      aluOut = opA | opB;
            XOR:     aluOut = opA ^ opB;
            SUL:     aluOut = opA << shamt;
            SSL:     aluOut = opA <<< shamt;
            SUR:     aluOut = opA >> shamt;
            SSR:     aluOut = $signed(opA) >>> shamt;
            EQ:      aluOut = `NIU_WORD'(opA == opB);
            NEQ:     aluOut = `NIU_WORD'(opA != opB);
            LT:      aluOut = `NIU_WORD'($signed(opA) < $signed(opB));
            LEQ:     aluOut = `NIU_WORD'($signed(opA) <= $signed(opB));
            default: aluOut = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (ctrl.ldA) begin
            opA <= operand;
        end
        if (ctrl.ldB) begin
            opB <= operand;
        end
        result <= aluOut;
    end

    assign cond = result[0];   // Compare outcome for branches

endmodule

// File: design/niuBusMaster.sv
`timescale 1ns/1ns
`include "niu_params.svh"

module niuBusMaster (
    input  logic                 clk,
    input  logic                 reset,
    input  niuPkg::ctrlBundle    ctrl,
    input  logic [`NIU_WORD-1:0] pc,
    input  logic [`NIU_WORD-1:0] aluResult,
    input  logic [`NIU_WORD-1:0] regData,
    output niuPkg::wbReq         bus,
    input  niuPkg::wbRsp         mem,
    output logic [`NIU_WORD-1:0] memData,
    output logic                 memDone
);
    import niuPkg::*;

    logic                 active;     // cyc and stb
    logic                 writeCyc;
    logic [`NIU_WORD-1:0] adrReg;
    logic [`NIU_WORD-1:0] datReg;

    assign memDone = active & mem.ack;

    // Cycle stays open until the first ack
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            active   <= 1'b0;
            writeCyc <= 1'b0;
        end else if (ctrl.memStart) begin
            active   <= 1'b1;
            writeCyc <= ctrl.memWrite;
        end else if (memDone) begin
            active   <= 1'b0;
            writeCyc <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.memStart) begin
            adrReg <= (ctrl.opSel == SRC_PCVAL) ? pc : aluResult;   // Fetch or data access
            datReg <= regData;
        end
        if (memDone) begin
            memData <= mem.datR;
        end
    end

    assign bus.cyc  = active;
    assign bus.stb  = active;
    assign bus.we   = writeCyc;
    assign bus.adr  = adrReg;
    assign bus.datW = datReg;

endmodule

// File: design/niuCore.sv
`timescale 1ns/1ns
`include "niu_params.svh"

module niuCore (
    input  logic         clk,
    input  logic         reset,
    output niuPkg::wbReq bus,
    input  niuPkg::wbRsp mem,
    output logic         halted
);
    import niuPkg::*;

    ctrlBundle            ctrl;
    decodedInstr          instr;
    logic [`NIU_WORD-1:0] pc;
    logic [`NIU_WORD-1:0] regData;
    logic [`NIU_WORD-1:0] aluResult;
    logic [`NIU_WORD-1:0] memData;
    logic                 memDone;
    logic                 cond;

    niuControl control0 (
        .clk     (clk),
        .reset   (reset),
        .instr   (instr),
        .memDone (memDone),
        .cond    (cond),
        .ctrl    (ctrl),
        .halted  (halted)
    );

    niuPcUnit pcUnit0 (
        .clk       (clk),
        .reset     (reset),
        .ctrl      (ctrl),
        .memData   (memData),
        .aluResult (aluResult),
        .regData   (regData),
        .pc        (pc),
        .instr     (instr)
    );

    niuRegFile regFile0 (
        .clk       (clk),
        .ctrl      (ctrl),
        .aluResult (aluResult),
        .memData   (memData),
        .pc        (pc),
        .regData   (regData)
    );

    niuAlu alu0 (
        .clk     (clk),
        .ctrl    (ctrl),
        .regData (regData),
        .pc      (pc),
        .imm     (instr.imm),
        .result  (aluResult),
        .cond    (cond)
    );

    niuBusMaster busMaster0 (
        .clk       (clk),
        .reset     (reset),
        .ctrl      (ctrl),
        .pc        (pc),
        .aluResult (aluResult),
        .regData   (regData),
        .bus       (bus),
        .mem       (mem),
        .memData   (memData),
        .memDone   (memDone)
    );

endmodule

// File: design/niuPcUnit.sv
`timescale 1ns/1ns
`include "niu_params.svh"

module niuPcUnit (
    input  logic                 clk,
    input  logic                 reset,
    input  niuPkg::ctrlBundle    ctrl,
    input  logic [`NIU_WORD-1:0] memData,
    input  logic [`NIU_WORD-1:0] aluResult,
    input  logic [`NIU_WORD-1:0] regData,
    output logic [`NIU_WORD-1:0] pc,
    output niuPkg::decodedInstr  instr
);
    import niuPkg::*;

    logic [`NIU_WORD-1:0] ir;

    // JAL takes the register, a branch the ALU sum
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= `NIU_PC_START;
        end else if (ctrl.ldPc) begin
            pc <= (ctrl.opSel == SRC_REGDATA) ? regData : aluResult;
        end else if (ctrl.incPc) begin
            pc <= pc + `NIU_PC_STEP;
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.ldIr) begin
            ir <= memData;
        end
    end

    // Field decode
    assign instr.op1 = primaryOp'(ir[`NIU_OP1_MSB:`NIU_OP1_LSB]);
    assign instr.rx  = ir[`NIU_RX_LSB +: `NIU_REG_BITS];
    assign instr.ry  = ir[`NIU_RY_LSB +: `NIU_REG_BITS];
    assign instr.rz  = ir[`NIU_RZ_LSB +: `NIU_REG_BITS];
    assign instr.op2 = aluFunc'(ir[`NIU_OP_BITS-1:0]);    // Overlaps imm low bits

    assign instr.imm = {{(`NIU_WORD - `NIU_IMM_BITS){ir[`NIU_IMM_BITS-1]}},
                        ir[`NIU_IMM_BITS-1:0]};

endmodule

// File: design/niuRegFile.sv
`timescale 1ns/1ns
`include "niu_params.svh"

module niuRegFile (
    input  logic                 clk,
    input  niuPkg::ctrlBundle    ctrl,
    input  logic [`NIU_WORD-1:0] aluResult,
    input  logic [`NIU_WORD-1:0] memData,
    input  logic [`NIU_WORD-1:0] pc,
    output logic [`NIU_WORD-1:0] regData
);
    import niuPkg::*;

    logic [`NIU_WORD-1:0] regs [2**`NIU_REG_BITS];
    logic [`NIU_WORD-1:0] wbWord;

    // Write-back source select
    always_comb begin
        case (ctrl.wbSel)
            WB_MEMDATA: wbWord = memData;
            WB_PCVAL:   wbWord = pc;          // JAL link
            default:    wbWord = aluResult;
        endcase
    end

    always_ff @(posedge clk) begin
        if (ctrl.wrReg) begin
            regs[ctrl.regSel] <= wbWord;
        end
    end

    assign regData = regs[ctrl.regSel];   // Asynchronous read

endmodule

// File: files.f
+incdir+common
common/niuPkg.sv
control/niuControl.sv
design/niuPcUnit.sv
design/niuRegFile.sv
design/niuAlu.sv
design/niuBusMaster.sv
design/niuCore.sv
sim/niuCoreTb_sva.sv
sim/niuCoreTb.sv

// File: sim/niuCoreTb.sv
`timescale 1ns/1ns
`include "niu_params.svh"

module niuCoreTb;
    import niuPkg::*;

    localparam int MEM_WORDS  = 256;
    localparam int MAX_STORES = 32;
    localparam int NUM_TESTS  = 5;
    localparam logic [`NIU_WORD-1:0] SENTINEL  = 32'h0000_BAD0;   // Must never be stored
    localparam logic [`NIU_WORD-1:0] DATA_WORD = 32'h1234_5678;
    localparam int RES = 32'h200;     // Result area
    localparam int DAT = 32'h300;     // Preloaded data word

    logic clk;
    logic reset;
    wbReq bus;
    wbRsp mem;
    logic halted;

    logic [`NIU_WORD-1:0] memArray [MEM_WORDS];
    logic [`NIU_WORD-1:0] expAdr [MAX_STORES];
    logic [`NIU_WORD-1:0] expDat [MAX_STORES];
    int    expTest [MAX_STORES];
    logic  expLast [MAX_STORES];
    string testNames [NUM_TESTS];
    int    testErrors [NUM_TESTS];
    int    progLen;
    int    numExp;
    int    storeIdx;
    int    errors;
    int    testsRun;
    int    testsFailed;
    int    seed;
    int    ackDelay;
    logic  waiting;
    int    jalAt;

    niuCore dut0 (
        .clk    (clk),
        .reset  (reset),
        .bus    (bus),
        .mem    (mem),
        .halted (halted)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] regInstr(aluFunc f, int rx, int ry, int rz);
        return {ALUR, 5'(rx), 5'(ry), 5'(rz), 7'b0, f};
    endfunction

    function automatic logic [31:0] immInstr(primaryOp op, int rx, int ry, int imm);
        return {op, 5'(rx), 5'(ry), 17'(imm)};
    endfunction

    task automatic emit(input logic [31:0] word);
        memArray[progLen] = word;
        progLen++;
    endtask

    task automatic expectStore(input int test, input int adr, input int dat);
        expTest[numExp] = test;
        expAdr[numExp]  = 32'(adr);
        expDat[numExp]  = 32'(dat);
        numExp++;
    endtask

    task automatic reportTest(input int t);
        testsRun++;
        if (testErrors[t] == 0) begin
            $display("Test %s: ok", testNames[t]);
        end else begin
            testsFailed++;
            $display("Test %s: %0d errors", testNames[t], testErrors[t]);
        end
    endtask

    task automatic buildProgram();
        int i;
        emit(regInstr(SUB, 0, 0, 1));          // r1 = 0 whatever r0 holds
        emit(immInstr(ADDI, 1, 2, RES));
        emit(immInstr(ADDI, 1, 3, 7));
        emit(immInstr(ADDI, 1, 4, -12));       // Negative immediate
        // Immediate ALU results go to ry
        emit(immInstr(SW, 2, 4, 0));
        expectStore(0, RES, -12);
        emit(immInstr(MLTI, 3, 5, 6));
        emit(immInstr(SW, 2, 5, 4));
        expectStore(0, RES + 4, 7 * 6);
        emit(immInstr(SSRI, 4, 6, 2));
        emit(immInstr(SW, 2, 6, 8));
        expectStore(0, RES + 8, -12 >>> 2);
        emit(immInstr(XORI, 3, 6, 'h1F));
        emit(immInstr(SW, 2, 6, 12));
        expectStore(0, RES + 12, 7 ^ 'h1F);
        emit(immInstr(ORI, 3, 6, -16));
        emit(immInstr(SW, 2, 6, 16));
        expectStore(0, RES + 16, 7 | -16);
        // Register ALU results go to rz
        emit(regInstr(SUB, 3, 4, 7));
        emit(immInstr(SW, 2, 7, 20));
        expectStore(1, RES + 20, 7 - (-12));
        emit(regInstr(MLT, 3, 4, 7));
        emit(immInstr(SW, 2, 7, 24));
        expectStore(1, RES + 24, 7 * -12);
        emit(regInstr(SSR, 4, 3, 7));
        emit(immInstr(SW, 2, 7, 28));
        expectStore(1, RES + 28, -12 >>> 7);
        emit(regInstr(SUL, 3, 3, 7));
        emit(immInstr(SW, 2, 7, 32));
        expectStore(1, RES + 32, 7 << 7);
        emit(regInstr(LT, 4, 3, 7));           // True as a signed compare
        emit(immInstr(SW, 2, 7, 36));
        expectStore(1, RES + 36, 1);
        emit(regInstr(LEQ, 3, 4, 7));
        emit(immInstr(SW, 2, 7, 40));
        expectStore(1, RES + 40, 0);
        emit(regInstr(XOR, 3, 4, 7));
        emit(immInstr(SW, 2, 7, 44));
        expectStore(1, RES + 44, 7 ^ -12);
        // Load, increment, store
        emit(immInstr(ADDI, 1, 8, DAT - 16));
        emit(immInstr(LW, 8, 9, 16));
        emit(immInstr(ADDI, 9, 9, 1));
        emit(immInstr(SW, 8, 9, 32));
        expectStore(2, DAT + 16, int'(DATA_WORD) + 1);
        // Taken branches skip the sentinel stores
        emit(immInstr(ADDI, 1, 10, int'(SENTINEL)));
        emit(immInstr(BEQ, 3, 3, 1));
        emit(immInstr(SW, 2, 10, 48));
        emit(immInstr(BNE, 3, 4, 1));
        emit(immInstr(SW, 2, 10, 48));
        emit(immInstr(BLT, 4, 3, 1));
        emit(immInstr(SW, 2, 10, 48));
        emit(immInstr(BLE, 3, 3, 1));
        emit(immInstr(SW, 2, 10, 48));
        emit(immInstr(BLT, 3, 4, 1));          // Not taken
        emit(immInstr(SW, 2, 3, 48));
        expectStore(3, RES + 48, 7);
        jalAt = (progLen + 1) * 4;
        emit(immInstr(ADDI, 1, 12, jalAt + 8));
        emit(immInstr(JAL, 12, 11, 0));
        emit(immInstr(SW, 2, 10, 52));
        emit(immInstr(SW, 2, 11, 52));
        expectStore(3, RES + 52, jalAt + 4);
        emit(32'hF000_0000);                   // Undefined opcode
        for (i = 0; i < numExp; i++) begin
            expLast[i] = (i == numExp - 1) || (expTest[i + 1] != expTest[i]);
        end
    endtask

    task automatic checkStore(input logic [31:0] adr, input logic [31:0] dat);
        int t;
        assert (storeIdx < numExp) else begin
            $display("Store to %h with %h after the last expected store", adr, dat);
            errors++;
        end
        if (storeIdx < numExp) begin
            t = expTest[storeIdx];
            assert (adr == expAdr[storeIdx] && dat == expDat[storeIdx]) else begin
                $display("Error in %s: expected %h at %h, actual %h at %h", testNames[t],
                         expDat[storeIdx], expAdr[storeIdx], dat, adr);
                errors++;
                testErrors[t]++;
            end
            if (expLast[storeIdx]) begin
                reportTest(t);
            end
            storeIdx++;
        end
    endtask

    // Slave with a random ack delay of 0 to 3 cycles
    always @(negedge clk) begin
        if (reset || mem.ack) begin
            mem.ack = 1'b0;
            waiting = 1'b0;
        end else if (bus.stb) begin
            if (!waiting) begin
                ackDelay = $random(seed) & 3;
                waiting  = 1'b1;
            end
            if (ackDelay == 0) begin
                if (bus.we) begin
                    checkStore(bus.adr, bus.datW);
                    memArray[bus.adr[9:2]] = bus.datW;
                end else begin
                    mem.datR = memArray[bus.adr[9:2]];
                end
                mem.ack = 1'b1;
                waiting = 1'b0;
            end else begin
                ackDelay--;
            end
        end
    end

    initial begin
        int i;
        reset    = 1'b1;
        mem      = '0;
        waiting  = 1'b0;
        ackDelay = 0;
        seed     = 80049;
        progLen  = 0;
        numExp   = 0;
        storeIdx = 0;
        errors   = 0;
        testsRun = 0;
        testsFailed = 0;
        testNames = '{"alu_imm", "alu_reg", "lw_sw", "branch_jal", "halt"};
        for (i = 0; i < NUM_TESTS; i++) begin
            testErrors[i] = 0;
        end
        for (i = 0; i < MEM_WORDS; i++) begin
            memArray[i] = 32'hC3C3_0000 ^ (32'(i) << 2);
        end
        memArray[DAT / 4] = DATA_WORD;
        buildProgram();
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        while (!halted) begin
            @(negedge clk);
        end
        repeat (10) @(negedge clk);
        assert (halted && !bus.cyc && storeIdx == numExp) else begin
            $display("Core left halt, kept the bus, or missed stores (%0d of %0d seen)",
                     storeIdx, numExp);
            errors++;
            testErrors[4]++;
        end
        reportTest(4);
        errors = errors + dut0.sva0.failCount;
        $display("%0d tests run, %0d failed, %0d errors, %0d assertion failures",
                 testsRun, testsFailed, errors, dut0.sva0.failCount);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // Watchdog allows 20 cycles per instruction and 4 times that for bus waits
    initial begin
        @(negedge reset);
        repeat (progLen * 20 * 4) @(posedge clk);
        $display("Timeout: the core did not halt within %0d cycles", progLen * 80);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// File: sim/niuCoreTb_sva.sv
`timescale 1ns/1ns
`include "niu_params.svh"

module niuCoreTb_sva (
    input logic         clk,
    input logic         reset,
    input niuPkg::wbReq bus,
    input niuPkg::wbRsp mem,
    input logic         halted
);
    import niuPkg::*;

    localparam logic [`NIU_WORD-1:0] SENTINEL = 32'h0000_BAD0;

    int   failCount = 0;
    logic seenCycle;    // Any bus cycle since reset

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            seenCycle <= 1'b0;
        end else if (bus.cyc) begin
            seenCycle <= 1'b1;
        end
    end

    idleInReset: assert property (@(posedge clk) reset |-> !bus.cyc && !bus.stb && !halted)
        else begin failCount++; $error("bus or halted active during reset"); end

    firstFetch: assert property (@(posedge clk) disable iff (reset)
        bus.cyc && !seenCycle |-> !bus.we && bus.adr == `NIU_PC_START)
        else begin failCount++; $error("first bus cycle is not a read at the start PC"); end

    heldUntilAck: assert property (@(posedge clk) disable iff (reset)
        bus.stb && !mem.ack |=> bus.stb && $stable(bus.adr) && $stable(bus.we)
                                && $stable(bus.datW))
        else begin failCount++; $error("request changed before ack"); end

    dropAfterAck: assert property (@(posedge clk) disable iff (reset)
        bus.stb && mem.ack |=> !bus.stb)
        else begin failCount++; $error("stb still high after ack"); end

    cleanStore: assert property (@(posedge clk) disable iff (reset)
        bus.stb && bus.we |-> bus.datW != SENTINEL && bus.adr[1:0] == 2'b00)
        else begin failCount++; $error("sentinel or unaligned store"); end

    quietHalt: assert property (@(posedge clk) disable iff (reset)
        halted |-> !bus.cyc ##1 halted)
        else begin failCount++; $error("bus cycle or exit while halted"); end

endmodule

bind niuCore niuCoreTb_sva sva0 (
    .clk    (clk),
    .reset  (reset),
    .bus    (bus),
    .mem    (mem),
    .halted (halted)
);
